//--- common/io_macros.svh
/* word addresses and sizes of the I/O corner
   addresses are word addresses, i.e. byte address bits 15:2 */
`ifndef IO_MACROS_SVH
`define IO_MACROS_SVH

// word address width, byte address bits 15:2
`define IO_ADR_W 14

// data bus width
`define IO_DATA_W 32

// command buffer entries, power of two and at least 2
`define CMD_FIFO_DEPTH 4

// io_led register map
`define ADR_LED      14'h3F80
`define ADR_STRAP    14'h3F81
`define ADR_GPIO_OUT 14'h3F84
`define ADR_GPIO_IN  14'h3F85
`define ADR_GPIO_OE  14'h3F86

`endif

//--- common/io_pkg.sv
/* shared types of the I/O command path
   opcode and bus master state encodings only; widths and addresses sit in io_macros.svh */
`default_nettype none

package io_pkg;

	// host command opcode
	// one bit wide, so it travels through the command buffer as is
	typedef enum logic [0:0] {
		IO_OP_READ  = 1'b0,
		IO_OP_WRITE = 1'b1
	} io_op_t;

	// bus master sequence per command
	// writes go idle -> issue -> idle
	// reads add capture and the two response phases
	typedef enum logic [2:0] {
		BUS_IDLE         = 3'd0,
		// one bus strobe (io_we or io_radr_en)
		BUS_ISSUE        = 3'd1,
		// io_rdata valid this cycle
		BUS_CAPTURE      = 3'd2,
		// rsp_req high, waiting for rsp_ack
		BUS_RESPOND_HIGH = 3'd3,
		// rsp_req low, waiting for rsp_ack to drop
		BUS_RESPOND_LOW  = 3'd4
	} bus_state_t;

endpackage

`default_nettype wire

//--- io_bus/io_cmd_intake.sv
/* host command port, four-phase req/ack
   the host holds op, address and data stable from cmd_req high until cmd_ack is seen,
   and starts the next command only once cmd_ack is low again */
`timescale 1ns/1ps
`default_nettype none
`include "io_macros.svh"

module io_cmd_intake (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cmd_req,
	input  io_pkg::io_op_t        cmd_op,
	input  logic [`IO_ADR_W-1:0]  cmd_adr,
	input  logic [`IO_DATA_W-1:0] cmd_wdata,
	output logic                  cmd_ack,
	input  logic                  full,
	output logic                  push,
	output io_pkg::io_op_t        push_op,
	output logic [`IO_ADR_W-1:0]  push_adr,
	output logic [`IO_DATA_W-1:0] push_wdata
);

	logic req_s;
	logic req_d;
	logic req_rise;
	logic pending;

	// request sync stage plus edge history
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_s <= 1'b0;
			req_d <= 1'b0;
		end else begin
			req_s <= cmd_req;
			req_d <= req_s;
		end
	end

	assign req_rise = req_s & ~req_d;

	// one push per handshake
	// a request that meets a full buffer waits in pending
	assign push = (req_rise | pending) & ~full;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pending <= 1'b0;
		else if (push)
			pending <= 1'b0;
		else if (req_rise)
			pending <= 1'b1;
	end

	// ack goes up the cycle after the push
	// and comes down once the host has let go of req
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cmd_ack <= 1'b0;
		else if (push)
			cmd_ack <= 1'b1;
		else if (!req_s)
			cmd_ack <= 1'b0;
	end

	// fields are stable for the whole handshake
	assign push_op    = cmd_op;
	assign push_adr   = cmd_adr;
	assign push_wdata = cmd_wdata;

endmodule

`default_nettype wire

//--- io_bus/io_cmd_fifo.sv
/* in-order command buffer, CMD_FIFO_DEPTH entries (power of two, at least 2)
   push while full and pop while empty are ignored; head fields valid while empty is low */
`timescale 1ns/1ps
`default_nettype none
`include "io_macros.svh"

module io_cmd_fifo (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  push,
	input  io_pkg::io_op_t        push_op,
	input  logic [`IO_ADR_W-1:0]  push_adr,
	input  logic [`IO_DATA_W-1:0] push_wdata,
	output logic                  full,
	input  logic                  pop,
	output logic                  empty,
	output io_pkg::io_op_t        head_op,
	output logic [`IO_ADR_W-1:0]  head_adr,
	output logic [`IO_DATA_W-1:0] head_wdata
);
	import io_pkg::*;

	localparam int AW = $clog2(`CMD_FIFO_DEPTH);

	io_op_t               op_mem    [`CMD_FIFO_DEPTH];
	logic [`IO_ADR_W-1:0]  adr_mem   [`CMD_FIFO_DEPTH];
	logic [`IO_DATA_W-1:0] wdata_mem [`CMD_FIFO_DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          do_push;
	logic          do_pop;

	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	assign full  = (count == (AW+1)'(`CMD_FIFO_DEPTH));
	assign empty = (count == '0);

	always_ff @(posedge clk) begin
		if (do_push) begin
			op_mem[wr_ptr]    <= push_op;
			adr_mem[wr_ptr]   <= push_adr;
			wdata_mem[wr_ptr] <= push_wdata;
		end
	end

	// pointers wrap on their own at a power of two depth
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head_op    = op_mem[rd_ptr];
	assign head_adr   = adr_mem[rd_ptr];
	assign head_wdata = wdata_mem[rd_ptr];

endmodule

`default_nettype wire

//--- io_bus/io_bus_master.sv
/* drains the command buffer one command at a time, strictly in order
   each read holds off the next command until both response phases are done */
`timescale 1ns/1ps
`default_nettype none
`include "io_macros.svh"

module io_bus_master (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  empty,
	input  io_pkg::io_op_t        head_op,
	input  logic [`IO_ADR_W-1:0]  head_adr,
	input  logic [`IO_DATA_W-1:0] head_wdata,
	output logic                  pop,
	output logic                  io_we,
	output logic [`IO_ADR_W-1:0]  io_wadr,
	output logic [`IO_DATA_W-1:0] io_wdata,
	output logic [`IO_ADR_W-1:0]  io_radr,
	output logic                  io_radr_en,
	input  logic [`IO_DATA_W-1:0] io_rdata,
	output logic                  rsp_req,
	output logic [`IO_DATA_W-1:0] rsp_rdata,
	input  logic                  rsp_ack
);
	import io_pkg::*;

	bus_state_t           state;
	bus_state_t           state_nxt;
	logic [`IO_ADR_W-1:0] bus_adr;

	// take the head as soon as it shows up in idle
	assign pop = (state == BUS_IDLE) & ~empty;

	always_comb begin
		state_nxt = state;
		case (state)
			BUS_IDLE: begin
				if (!empty)
					state_nxt = BUS_ISSUE;
			end
			// strobes were loaded on the pop, so io_radr_en tells the op
			BUS_ISSUE:   state_nxt = io_radr_en ? BUS_CAPTURE : BUS_IDLE;
			BUS_CAPTURE: state_nxt = BUS_RESPOND_HIGH;
			BUS_RESPOND_HIGH: begin
				if (rsp_ack)
					state_nxt = BUS_RESPOND_LOW;
			end
			BUS_RESPOND_LOW: begin
				if (!rsp_ack)
					state_nxt = BUS_IDLE;
			end
			default: state_nxt = BUS_IDLE;
		endcase
	end

	// strobes last exactly the one cycle after the pop
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= BUS_IDLE;
			io_we      <= 1'b0;
			io_radr_en <= 1'b0;
		end else begin
			state      <= state_nxt;
			io_we      <= pop & (head_op == IO_OP_WRITE);
			io_radr_en <= pop & (head_op == IO_OP_READ);
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			bus_adr  <= head_adr;
			io_wdata <= head_wdata;
		end
		// read data is on the bus only during capture
		if (state == BUS_CAPTURE)
			rsp_rdata <= io_rdata;
	end

	// one address register serves both bus directions
	assign io_wadr = bus_adr;
	assign io_radr = bus_adr;

	assign rsp_req = (state == BUS_RESPOND_HIGH);

endmodule

`default_nettype wire

//--- verilog/io_led.sv
/* LED, breakpoint indicator, GPIO and boot strap registers on the I/O bus
   read data is valid the cycle after io_radr_en only; unmapped reads return zero
   strap and GPIO pin reads lag the pins by two cycles */
`timescale 1ns/1ps
`default_nettype none
`include "io_macros.svh"

module io_led (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  io_we,
	input  logic [`IO_ADR_W-1:0]  io_wadr,
	input  logic [`IO_DATA_W-1:0] io_wdata,
	input  logic [`IO_ADR_W-1:0]  io_radr,
	input  logic                  io_radr_en,
	output logic [`IO_DATA_W-1:0] io_rdata,
	output logic [2:0]            rgb_led,
	input  logic [2:0]            dbg_bpoint_en,
	input  logic [2:0]            dbg_bpoint,
	input  logic                  cpu_start,
	input  logic [1:0]            init_uart,
	input  logic [1:0]            init_latency,
	input  logic                  init_cpu_start,
	input  logic                  gpi_in,
	input  logic [3:0]            gpio_in,
	output logic [3:0]            gpio_out,
	output logic [3:0]            gpio_oe
);

	// read select bit positions
	localparam int SEL_LED      = 0;
	localparam int SEL_STRAP    = 1;
	localparam int SEL_GPIO_OUT = 2;
	localparam int SEL_GPIO_IN  = 3;
	localparam int SEL_GPIO_OE  = 4;

	logic [2:0] led_value;
	logic       bp_any_en;
	logic       bp_hit;
	logic       bp_flag;
	logic [5:0] strap_s1;
	logic [5:0] strap_s2;
	logic [3:0] gpio_s1;
	logic [3:0] gpio_s2;
	logic [4:0] rd_sel;
	logic [4:0] rd_sel_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_value <= '0;
			gpio_out  <= '0;
			gpio_oe   <= '0;
		end else if (io_we) begin
			if (io_wadr == `ADR_LED)
				led_value <= io_wdata[2:0];
			if (io_wadr == `ADR_GPIO_OUT)
				gpio_out <= io_wdata[3:0];
			if (io_wadr == `ADR_GPIO_OE)
				gpio_oe <= io_wdata[3:0];
		end
	end

	// sticky breakpoint flag, cpu_start wins over a new hit
	assign bp_any_en = |dbg_bpoint_en;
	assign bp_hit    = |(dbg_bpoint_en & dbg_bpoint);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			bp_flag <= 1'b0;
		else if (cpu_start)
			bp_flag <= 1'b0;
		else if (bp_hit)
			bp_flag <= 1'b1;
	end

	assign rgb_led = {bp_any_en ? bp_flag : led_value[2], led_value[1:0]};

	// two flop synchronizers for the pins
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			strap_s1 <= '0;
			strap_s2 <= '0;
			gpio_s1  <= '0;
			gpio_s2  <= '0;
		end else begin
			strap_s1 <= {init_uart, init_cpu_start, init_latency, gpi_in};
			strap_s2 <= strap_s1;
			gpio_s1  <= gpio_in;
			gpio_s2  <= gpio_s1;
		end
	end

	always_comb begin
		rd_sel               = '0;
		rd_sel[SEL_LED]      = io_radr_en & (io_radr == `ADR_LED);
		rd_sel[SEL_STRAP]    = io_radr_en & (io_radr == `ADR_STRAP);
		rd_sel[SEL_GPIO_OUT] = io_radr_en & (io_radr == `ADR_GPIO_OUT);
		rd_sel[SEL_GPIO_IN]  = io_radr_en & (io_radr == `ADR_GPIO_IN);
		rd_sel[SEL_GPIO_OE]  = io_radr_en & (io_radr == `ADR_GPIO_OE);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_sel_q <= '0;
		else
			rd_sel_q <= rd_sel;
	end

	// at most one select bit is set
	always_comb begin
		io_rdata = '0;
		if (rd_sel_q[SEL_LED])
			io_rdata[2:0] = led_value;
		if (rd_sel_q[SEL_STRAP])
			io_rdata[5:0] = strap_s2;
		if (rd_sel_q[SEL_GPIO_OUT])
			io_rdata[3:0] = gpio_out;
		if (rd_sel_q[SEL_GPIO_IN])
			io_rdata[3:0] = gpio_s2;
		if (rd_sel_q[SEL_GPIO_OE])
			io_rdata[3:0] = gpio_oe;
	end

endmodule

`default_nettype wire

//--- verilog/io_subsys_top.sv
/* I/O corner top: host command port, command buffer, bus master and io_led
   GPIO pad is split into gpio_in, gpio_out and gpio_oe; the pad itself lives outside */
`timescale 1ns/1ps
`default_nettype none
`include "io_macros.svh"

module io_subsys_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cmd_req,
	input  io_pkg::io_op_t        cmd_op,
	input  logic [`IO_ADR_W-1:0]  cmd_adr,
	input  logic [`IO_DATA_W-1:0] cmd_wdata,
	output logic                  cmd_ack,
	output logic                  rsp_req,
	output logic [`IO_DATA_W-1:0] rsp_rdata,
	input  logic                  rsp_ack,
	output logic [2:0]            rgb_led,
	input  logic [2:0]            dbg_bpoint_en,
	input  logic [2:0]            dbg_bpoint,
	input  logic                  cpu_start,
	input  logic [1:0]            init_uart,
	input  logic [1:0]            init_latency,
	input  logic                  init_cpu_start,
	input  logic                  gpi_in,
	input  logic [3:0]            gpio_in,
	output logic [3:0]            gpio_out,
	output logic [3:0]            gpio_oe
);
	import io_pkg::*;

	// intake to buffer
	logic                  push;
	io_op_t                push_op;
	logic [`IO_ADR_W-1:0]  push_adr;
	logic [`IO_DATA_W-1:0] push_wdata;
	logic                  full;

	// buffer to bus master
	logic                  pop;
	logic                  empty;
	io_op_t                head_op;
	logic [`IO_ADR_W-1:0]  head_adr;
	logic [`IO_DATA_W-1:0] head_wdata;

	// I/O bus
	logic                  io_we;
	logic [`IO_ADR_W-1:0]  io_wadr;
	logic [`IO_DATA_W-1:0] io_wdata;
	logic [`IO_ADR_W-1:0]  io_radr;
	logic                  io_radr_en;
	logic [`IO_DATA_W-1:0] io_rdata;

	io_cmd_intake u_io_cmd_intake (
		.clk        (clk),
		.rst_n      (rst_n),
		.cmd_req    (cmd_req),
		.cmd_op     (cmd_op),
		.cmd_adr    (cmd_adr),
		.cmd_wdata  (cmd_wdata),
		.cmd_ack    (cmd_ack),
		.full       (full),
		.push       (push),
		.push_op    (push_op),
		.push_adr   (push_adr),
		.push_wdata (push_wdata)
	);

	io_cmd_fifo u_io_cmd_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (push),
		.push_op    (push_op),
		.push_adr   (push_adr),
		.push_wdata (push_wdata),
		.full       (full),
		.pop        (pop),
		.empty      (empty),
		.head_op    (head_op),
		.head_adr   (head_adr),
		.head_wdata (head_wdata)
	);

	io_bus_master u_io_bus_master (
		.clk        (clk),
		.rst_n      (rst_n),
		.empty      (empty),
		.head_op    (head_op),
		.head_adr   (head_adr),
		.head_wdata (head_wdata),
		.pop        (pop),
		.io_we      (io_we),
		.io_wadr    (io_wadr),
		.io_wdata   (io_wdata),
		.io_radr    (io_radr),
		.io_radr_en (io_radr_en),
		.io_rdata   (io_rdata),
		.rsp_req    (rsp_req),
		.rsp_rdata  (rsp_rdata),
		.rsp_ack    (rsp_ack)
	);

	io_led u_io_led (
		.clk            (clk),
		.rst_n          (rst_n),
		.io_we          (io_we),
		.io_wadr        (io_wadr),
		.io_wdata       (io_wdata),
		.io_radr        (io_radr),
		.io_radr_en     (io_radr_en),
		.io_rdata       (io_rdata),
		.rgb_led        (rgb_led),
		.dbg_bpoint_en  (dbg_bpoint_en),
		.dbg_bpoint     (dbg_bpoint),
		.cpu_start      (cpu_start),
		.init_uart      (init_uart),
		.init_latency   (init_latency),
		.init_cpu_start (init_cpu_start),
		.gpi_in         (gpi_in),
		.gpio_in        (gpio_in),
		.gpio_out       (gpio_out),
		.gpio_oe        (gpio_oe)
	);

endmodule

`default_nettype wire

//--- sim/io_subsys_checker.sv
/* protocol checks on the host handshakes and the I/O bus strobes
   bound into io_subsys_top; all checks are off while rst_n is low */
`timescale 1ns/1ps
`default_nettype none
`include "io_macros.svh"

module io_subsys_checker (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  cmd_req,
	input logic                  cmd_ack,
	input logic                  rsp_req,
	input logic                  rsp_ack,
	input logic [`IO_DATA_W-1:0] rsp_rdata,
	input logic                  io_we,
	input logic                  io_radr_en
);

	// read by the testbench at the end of the run
	int assert_fail_count = 0;

	// ack only answers a request
	ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cmd_ack) |-> $past(cmd_req))
	else begin
		$error("cmd_ack rose without cmd_req");
		assert_fail_count++;
	end

	// host holds cmd_req until it sees cmd_ack
	cmd_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(cmd_req) |-> cmd_ack)
	else begin
		$error("cmd_req dropped before cmd_ack");
		assert_fail_count++;
	end

	rsp_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(rsp_req) |-> $past(rsp_ack))
	else begin
		$error("rsp_req dropped before rsp_ack");
		assert_fail_count++;
	end

	no_strobe_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(io_we && io_radr_en))
	else begin
		$error("io_we and io_radr_en high together");
		assert_fail_count++;
	end

	rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_req && $past(rsp_req) |-> $stable(rsp_rdata))
	else begin
		$error("rsp_rdata changed while rsp_req was high");
		assert_fail_count++;
	end

endmodule

bind io_subsys_top io_subsys_checker u_io_subsys_checker (
	.clk        (clk),
	.rst_n      (rst_n),
	.cmd_req    (cmd_req),
	.cmd_ack    (cmd_ack),
	.rsp_req    (rsp_req),
	.rsp_ack    (rsp_ack),
	.rsp_rdata  (rsp_rdata),
	.io_we      (io_we),
	.io_radr_en (io_radr_en)
);

`default_nettype wire

//--- sim/io_subsys_tb.sv
/* vector-driven testbench for io_subsys_top, run from the project root
   reads sim/io_subsys_vectors.txt; read responses are checked in command order
   pin expectations pack {rgb_led, gpio_oe, gpio_out} as three hex digits */
`timescale 1ns/1ps
`default_nettype none
`include "io_macros.svh"

module io_subsys_tb;
	import io_pkg::*;

	localparam int KIND_W        = 96;
	localparam int CMD_TIMEOUT   = 400;
	localparam int RSP_TIMEOUT   = 600;
	localparam int OUT_TIMEOUT   = 400;
	localparam int DRAIN_TIMEOUT = 2000;

	logic                  clk;
	logic                  rst_n;
	logic                  cmd_req;
	io_op_t                cmd_op;
	logic [`IO_ADR_W-1:0]  cmd_adr;
	logic [`IO_DATA_W-1:0] cmd_wdata;
	logic                  cmd_ack;
	logic                  rsp_req;
	logic [`IO_DATA_W-1:0] rsp_rdata;
	logic                  rsp_ack;
	logic [2:0]            rgb_led;
	logic [2:0]            dbg_bpoint_en;
	logic [2:0]            dbg_bpoint;
	logic                  cpu_start;
	logic [1:0]            init_uart;
	logic [1:0]            init_latency;
	logic                  init_cpu_start;
	logic                  gpi_in;
	logic [3:0]            gpio_in;
	logic [3:0]            gpio_out;
	logic [3:0]            gpio_oe;

	// expected read data, oldest first
	logic [`IO_DATA_W-1:0] rsp_exp_q[$];
	integer                seed = 32'hd569_13c6;

	io_subsys_top u_io_subsys_top (.*);

	always #4 clk = ~clk;

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	// inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_rdata(input string name, input logic [`IO_DATA_W-1:0] got,
			input logic [`IO_DATA_W-1:0] exp);
		if (got !== exp)
			fail_now($sformatf("FAIL %s: got 0x%08h expected 0x%08h", name, got, exp));
	endtask

	task automatic check_pins(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp)
			fail_now($sformatf("FAIL %s: got 0x%01h expected 0x%01h", name, got, exp));
	endtask

	task automatic wait_cmd_ack(input logic level);
		int cycles;
		cycles = 0;
		while (cmd_ack !== level) begin
			next_cycle();
			cycles++;
			if (cycles > CMD_TIMEOUT)
				fail_now($sformatf("timeout waiting for cmd_ack to go %0d", level));
		end
	endtask

	task automatic wait_rsp_req(input logic level);
		int cycles;
		cycles = 0;
		while (rsp_req !== level) begin
			next_cycle();
			cycles++;
			if (cycles > RSP_TIMEOUT)
				fail_now($sformatf("timeout waiting for rsp_req to go %0d", level));
		end
	endtask

	// every queued read has been answered by the DUT
	task automatic wait_reads_done();
		int cycles;
		cycles = 0;
		while (rsp_exp_q.size() != 0) begin
			next_cycle();
			cycles++;
			if (cycles > DRAIN_TIMEOUT)
				fail_now("timeout waiting for outstanding read responses");
		end
	endtask

	// one four-phase command, returns once ack was seen and req is down
	task automatic host_command(input io_op_t op, input logic [`IO_ADR_W-1:0] adr,
			input logic [`IO_DATA_W-1:0] wdata);
		wait_cmd_ack(1'b0);
		cmd_op    = op;
		cmd_adr   = adr;
		cmd_wdata = wdata;
		cmd_req   = 1'b1;
		wait_cmd_ack(1'b1);
		cmd_req = 1'b0;
	endtask

	// writes may still sit in the buffer behind slow read responses
	task automatic check_outputs(input logic [`IO_DATA_W-1:0] exp);
		int cycles;
		cycles = 0;
		while ({1'b0, rgb_led, gpio_oe, gpio_out} !== exp[11:0] && cycles < OUT_TIMEOUT) begin
			next_cycle();
			cycles++;
		end
		check_pins("rgb_led", {1'b0, rgb_led}, exp[11:8]);
		check_pins("gpio_oe", gpio_oe, exp[7:4]);
		check_pins("gpio_out", gpio_out, exp[3:0]);
	endtask

	task automatic run_vector(input logic [KIND_W-1:0] kind, input logic [31:0] a,
			input logic [31:0] d, input logic [31:0] e);
		if (kind == KIND_W'("write")) begin
			host_command(IO_OP_WRITE, a[`IO_ADR_W-1:0], d);
		end else if (kind == KIND_W'("read")) begin
			rsp_exp_q.push_back(e);
			host_command(IO_OP_READ, a[`IO_ADR_W-1:0], '0);
		end else if (kind == KIND_W'("pins")) begin
			// reads still in the buffer must see the old pin levels
			wait_reads_done();
			gpio_in = a[3:0];
			{init_uart, init_cpu_start, init_latency, gpi_in} = d[5:0];
			// two sync stages plus margin
			repeat (3) next_cycle();
			check_outputs(e);
		end else if (kind == KIND_W'("breakpoint")) begin
			dbg_bpoint_en = a[2:0];
			dbg_bpoint    = d[2:0];
			next_cycle();
			dbg_bpoint = '0;
			check_outputs(e);
		end else if (kind == KIND_W'("start")) begin
			cpu_start = 1'b1;
			next_cycle();
			cpu_start = 1'b0;
			check_outputs(e);
		end else begin
			fail_now("unknown operation kind in the vector file");
		end
	endtask

	// a failed protocol assertion ends the run right away
	always @(posedge clk) begin
		if (u_io_subsys_top.u_io_subsys_checker.assert_fail_count != 0)
			fail_now("protocol assertions failed during the run");
	end

	// answers each read response after a random delay
	initial begin : responder
		int                    ack_delay;
		logic [`IO_DATA_W-1:0] exp;
		forever begin
			next_cycle();
			if (rsp_exp_q.size() != 0) begin
				wait_rsp_req(1'b1);
				exp = rsp_exp_q.pop_front();
				check_rdata("rsp_rdata", rsp_rdata, exp);
				ack_delay = $unsigned($random(seed)) % 16;
				repeat (ack_delay) next_cycle();
				rsp_ack = 1'b1;
				wait_rsp_req(1'b0);
				rsp_ack = 1'b0;
			end else if (rsp_req) begin
				fail_now("read response arrived with no read outstanding");
			end
		end
	end

	initial begin : main
		int                fd;
		int                n;
		int                cycles;
		logic              done;
		logic [KIND_W-1:0] kind;
		logic [8*128-1:0]  rest;
		logic [31:0]       arg_a;
		logic [31:0]       arg_d;
		logic [31:0]       arg_e;
		clk            = 1'b0;
		rst_n          = 1'b0;
		cmd_req        = 1'b0;
		cmd_op         = IO_OP_READ;
		cmd_adr        = '0;
		cmd_wdata      = '0;
		rsp_ack        = 1'b0;
		dbg_bpoint_en  = '0;
		dbg_bpoint     = '0;
		cpu_start      = 1'b0;
		init_uart      = '0;
		init_latency   = '0;
		init_cpu_start = 1'b0;
		gpi_in         = 1'b0;
		gpio_in        = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		fd = $fopen("sim/io_subsys_vectors.txt", "r");
		if (fd == 0)
			fail_now("cannot open sim/io_subsys_vectors.txt");
		done = 1'b0;
		while (!done) begin
			n = $fscanf(fd, "%s", kind);
			if (n != 1) begin
				done = 1'b1;
			end else if (kind == KIND_W'("#")) begin
				// skip the rest of a comment line
				n = $fgets(rest, fd);
			end else begin
				n = $fscanf(fd, "%h %h %h", arg_a, arg_d, arg_e);
				if (n != 3)
					fail_now("vector line is missing a column");
				run_vector(kind, arg_a, arg_d, arg_e);
			end
		end
		$fclose(fd);
		// let the last responses and handshakes finish
		cycles = 0;
		while (rsp_exp_q.size() != 0 || rsp_req || rsp_ack || cmd_ack) begin
			next_cycle();
			cycles++;
			if (cycles > DRAIN_TIMEOUT)
				fail_now("outstanding read responses never arrived");
		end
		if (u_io_subsys_top.u_io_subsys_checker.assert_fail_count != 0) begin
			fail_now("protocol assertions failed during the run");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sim/io_subsys_vectors.txt
# kind  adr_or_gpio_in  data_or_strap_or_bpoint  expected (read data, or rgb_led/gpio_oe/gpio_out)
# pins: gpio_in and the six strap pins; breakpoint: enables and a one-cycle breakpoint pulse
pins          0          2d   000
read       3f80           0     0
read       3f81           0    2d
read       3f84           0     0
read       3f85           0     0
read       3f86           0     0
write      3f80    fffffffe     0
pins          0          2d   600
read       3f80           0     6
write      3f84           a     0
write      3f86           c     0
pins          9          2d   6ca
read       3f84           0     a
read       3f86           0     c
read       3f85           0     9
breakpoint    1           0   2ca
breakpoint    1           1   6ca
breakpoint    1           0   6ca
start         0           0   2ca
breakpoint    2           1   2ca
breakpoint    2           2   6ca
write      3f80           1     0
pins          9          2d   5ca
breakpoint    0           0   1ca
write      3f84           3     0
read       3f84           0     3
write      3f86           5     0
read       3f86           0     5
read       0000           0     0
write      1234    ffffffff     0
write      3f84           7     0
read       3f84           0     7
read       3f87           0     0
write      3f80           2     0
read       3f80           0     2
read       3f81           0    2d
pins          6          1a   257
read       3f85           0     6
read       3f81           0    1a

//--- build.f
+incdir+common
common/io_pkg.sv
io_bus/io_cmd_intake.sv
io_bus/io_cmd_fifo.sv
io_bus/io_bus_master.sv
verilog/io_led.sv
verilog/io_subsys_top.sv
sim/io_subsys_checker.sv
sim/io_subsys_tb.sv

//--- Makefile
# Verilator regression for the I/O subsystem, run from the project root

VERILATOR ?= verilator
TOP       ?= io_subsys_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
